/* tb/frontend_stim.txt */
// Tag 1 line: addr word0 word1 word2 word3 | tag 2 reg write: idx value
// Tag 3 redirect: after_count target | tag 4 hold: after_count cycles
// Tag 5 expected: pc rd rs1_val rs2_val imm ctl{br,rw,mr,m2r,mw,asrc,alu_op} | tag 0 end
1 00001000 002082B3 FFF00313 0081A383 FE20AE23
1 00001010 00008863 0030827F 000004B3 40218533
1 00001040 00312A23 FE311CE3 80002083 00000013
2 1 11111111
2 2 22222222
2 3 00000033
2 0 DEADBEEF
4 2 5
4 5 3
3 8 00001040
5 00001000 5 11111111 22222222 00000000 42
5 00001004 6 00000000 00000000 FFFFFFFF 46
5 00001008 7 00000033 00000000 00000008 74
5 0000100C 1C 11111111 22222222 FFFFFFFC 0C
5 00001010 10 11111111 00000000 00000010 83
5 00001014 4 11111111 00000033 00000000 00
5 00001018 9 00000000 00000000 00000000 42
5 0000101C A 00000033 22222222 00000000 42
5 00001040 14 22222222 00000033 00000014 0C
5 00001044 19 22222222 00000033 FFFFFFF8 83
5 00001048 1 00000000 00000000 FFFFF800 74
5 0000104C 0 00000000 00000000 00000000 46
0

/* filelist.f */
hw/core_pkg.sv
hw/register_file.sv
hw/icache.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/frontend_top.sv
tb/frontend_tb.sv

/* Makefile */
# Verilator build and run for the front end testbench

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

  logic                           clk;
  logic                           rst;
  logic                           mem_req;
  logic [core_pkg::xlen-1:0]      mem_addr;
  logic                           mem_ack;
  logic [core_pkg::line_w-1:0]    mem_line;
  logic                           wb_en;
  logic [core_pkg::reg_idx_w-1:0] wb_idx;
  logic [core_pkg::xlen-1:0]      wb_data;
  logic                           redirect;
  logic [core_pkg::xlen-1:0]      redirect_pc;
  logic                           hold;
  logic                           out_valid;
  logic [core_pkg::xlen-1:0]      out_pc;
  logic [core_pkg::reg_idx_w-1:0] out_rd;
  logic [core_pkg::xlen-1:0]      out_rs1_val;
  logic [core_pkg::xlen-1:0]      out_rs2_val;
  logic [core_pkg::xlen-1:0]      out_imm;
  logic                           out_branch;
  logic                           out_reg_write;
  logic                           out_mem_read;
  logic                           out_mem_to_reg;
  logic                           out_mem_write;
  logic                           out_alu_src;
  logic [1:0]                     out_alu_op;

  // Parsed stim records
  logic [31:0]  stim [0:511];
  logic [31:0]  img_addr [0:15];
  logic [core_pkg::line_w-1:0] img_line [0:15];
  logic [31:0]  wr_idx_a [0:31];
  logic [31:0]  wr_val_a [0:31];
  logic [31:0]  redir_after [0:7];
  logic [31:0]  redir_target [0:7];
  logic [31:0]  hold_after [0:7];
  logic [31:0]  hold_len [0:7];
  logic [31:0]  exp_rec [0:31][0:5];
  int n_img, n_wr, n_redir, n_hold, n_exp;

  int errors, checks, consumed, hold_idx, hold_cnt, redir_idx, seed, delay;
  int hold_total;
  longint limit_ns;
  logic mem_enable, hold_now, redir_now, was_holding, prev_req;
  logic [31:0] snap_pc, snap_imm, prev_addr;
  int req_seen [logic [31:0]];

  frontend_top dut_i (.*);

  always #2 clk = ~clk;

  task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    checks++;
    if (exp_v !== act_v)
    begin
      errors++;
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  // Lines outside the image get a pattern built from each word address
  function automatic logic [core_pkg::line_w-1:0] line_for(input logic [31:0] addr);
    logic [core_pkg::line_w-1:0] line;
    line = '0;
    for (int k = 0; k < core_pkg::words_per_line; k++)
    begin
      line[k*32 +: 32] = ~(addr + 32'(k * 4));
    end
    for (int j = 0; j < n_img; j++)
    begin
      if (img_addr[j] == addr)
      begin
        line = img_line[j];
      end
    end
    return line;
  endfunction

  task automatic load_stim();
    int p;
    logic done;
    p = 0;
    done = 1'b0;
    for (int i = 0; i < 512; i++)
    begin
      stim[i] = '0;
    end
    $readmemh("tb/frontend_stim.txt", stim);
    while (!done && p < 500)
    begin
      case (stim[p])
        32'd0: done = 1'b1;
        32'd1:
        begin
          // Word 0 sits in the low bits of the line
          img_addr[n_img] = stim[p+1];
          img_line[n_img] = {stim[p+5], stim[p+4], stim[p+3], stim[p+2]};
          n_img++;
          p += 6;
        end
        32'd2:
        begin
          wr_idx_a[n_wr] = stim[p+1];
          wr_val_a[n_wr] = stim[p+2];
          n_wr++;
          p += 3;
        end
        32'd3:
        begin
          redir_after[n_redir]  = stim[p+1];
          redir_target[n_redir] = stim[p+2];
          n_redir++;
          p += 3;
        end
        32'd4:
        begin
          hold_after[n_hold] = stim[p+1];
          hold_len[n_hold]   = stim[p+2];
          hold_total += int'(stim[p+2]);
          n_hold++;
          p += 3;
        end
        32'd5:
        begin
          for (int f = 0; f < 6; f++)
          begin
            exp_rec[n_exp][f] = stim[p+1+f];
          end
          n_exp++;
          p += 7;
        end
        default:
        begin
          errors++;
          $display("Stim file holds an unknown record tag %h", stim[p]);
          done = 1'b1;
        end
      endcase
    end
  endtask

  // Memory model answering the four-phase refill
  initial
  begin
    mem_ack  <= 1'b0;
    mem_line <= '0;
    wait (mem_enable);
    forever
    begin
      @(negedge clk);
      if (mem_req && !mem_ack)
      begin
        delay = int'($unsigned($random(seed)) % 4);
        repeat (delay) @(negedge clk);
        mem_line <= line_for(mem_addr);
        mem_ack  <= 1'b1;
        @(negedge clk);
        while (mem_req) @(negedge clk);
        delay = int'($unsigned($random(seed)) % 3);
        repeat (delay) @(negedge clk);
        mem_ack <= 1'b0;
      end
    end
  end

  // Handshake ordering and one request per cached line
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (mem_req && !prev_req)
      begin
        if (mem_ack)
        begin
          errors++;
          $display("Refill request raised at %0t ns while ack was still high", $time);
        end
        if (req_seen.exists(mem_addr))
        begin
          errors++;
          $display("Line %h was requested a second time at %0t ns", mem_addr, $time);
        end
        req_seen[mem_addr] = 1;
      end
      if (prev_req && mem_req && !mem_ack && mem_addr != prev_addr)
      begin
        errors++;
        $display("Refill address changed before ack at %0t ns", $time);
      end
      if (prev_req && !mem_req && !mem_ack)
      begin
        errors++;
        $display("Refill request dropped before ack at %0t ns", $time);
      end
    end
    prev_req  = mem_req;
    prev_addr = mem_addr;
  end

  initial
  begin
    wait (mem_enable);
    limit_ns = longint'((n_exp * 16 + hold_total + 200) * 4);
    #(limit_ns);
    $display("Timeout: only %0d of %0d expected outputs arrived", consumed, n_exp);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    wb_en = 1'b0;
    wb_idx = '0;
    wb_data = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    hold = 1'b0;
    mem_enable = 1'b0;
    seed = 87;
    was_holding = 1'b0;
    prev_req = 1'b0;
    load_stim();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    // Sampled before the first edge out of reset
    check("out_valid after reset", 32'd0, 32'(out_valid));
    check("mem_req after reset", 32'd0, 32'(mem_req));
    // Register writes land before any line arrives
    for (int w = 0; w < n_wr; w++)
    begin
      wb_en   = 1'b1;
      wb_idx  = wr_idx_a[w][4:0];
      wb_data = wr_val_a[w];
      @(negedge clk);
    end
    wb_en = 1'b0;
    mem_enable = 1'b1;
    while (consumed < n_exp)
    begin
      @(negedge clk);
      if (was_holding)
      begin
        check("out_valid in hold", 32'd1, 32'(out_valid));
        check("out_pc in hold", snap_pc, out_pc);
        check("out_imm in hold", snap_imm, out_imm);
      end
      if (hold_idx < n_hold && hold_cnt == 0 && consumed == int'(hold_after[hold_idx]))
      begin
        hold_cnt = int'(hold_len[hold_idx]);
        hold_idx++;
      end
      hold_now = (hold_cnt > 0);
      if (hold_now)
      begin
        hold_cnt--;
      end
      redir_now = (redir_idx < n_redir) && (consumed == int'(redir_after[redir_idx]));
      hold = hold_now;
      redirect = redir_now;
      redirect_pc = redir_now ? redir_target[redir_idx] : '0;
      if (redir_now)
      begin
        redir_idx++;
      end
      was_holding = hold_now && out_valid;
      snap_pc = out_pc;
      snap_imm = out_imm;
      if (out_valid && !hold_now && !redir_now)
      begin
        if (consumed == 0)
        begin
          check("first out_pc", core_pkg::reset_pc, out_pc);
        end
        check("out_pc", exp_rec[consumed][0], out_pc);
        check("out_rd", exp_rec[consumed][1], 32'(out_rd));
        check("out_rs1_val", exp_rec[consumed][2], out_rs1_val);
        check("out_rs2_val", exp_rec[consumed][3], out_rs2_val);
        check("out_imm", exp_rec[consumed][4], out_imm);
        check("control", exp_rec[consumed][5],
              32'({out_branch, out_reg_write, out_mem_read, out_mem_to_reg,
                   out_mem_write, out_alu_src, out_alu_op}));
        consumed++;
      end
    end
    $display("Checks: %0d, errors: %0d, outputs: %0d", checks, errors, consumed);
    if (errors == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
  input  wire                             clk,
  input  wire                             rst,
  output logic                            mem_req,
  output logic [core_pkg::xlen-1:0]       mem_addr,
  input  wire                             mem_ack,
  input  wire  [core_pkg::line_w-1:0]     mem_line,
  input  wire                             wb_en,
  input  wire  [core_pkg::reg_idx_w-1:0]  wb_idx,
  input  wire  [core_pkg::xlen-1:0]       wb_data,
  input  wire                             redirect,
  input  wire  [core_pkg::xlen-1:0]       redirect_pc,
  input  wire                             hold,
  output logic                            out_valid,
  output logic [core_pkg::xlen-1:0]       out_pc,
  output logic [core_pkg::reg_idx_w-1:0]  out_rd,
  output logic [core_pkg::xlen-1:0]       out_rs1_val,
  output logic [core_pkg::xlen-1:0]       out_rs2_val,
  output logic [core_pkg::xlen-1:0]       out_imm,
  output logic                            out_branch,
  output logic                            out_reg_write,
  output logic                            out_mem_read,
  output logic                            out_mem_to_reg,
  output logic                            out_mem_write,
  output logic                            out_alu_src,
  output logic [1:0]                      out_alu_op
);

  // Cache to fetch
  logic [core_pkg::xlen-1:0]      pc;
  logic                           hit;
  logic [core_pkg::xlen-1:0]      inst;

  // Fetch register to decode
  logic                           f_valid;
  logic [core_pkg::xlen-1:0]      f_pc;
  logic [core_pkg::xlen-1:0]      f_inst;
  logic                           stall;

  // Decode to register file
  logic [core_pkg::reg_idx_w-1:0] rs1_idx;
  logic [core_pkg::reg_idx_w-1:0] rs2_idx;
  logic [core_pkg::xlen-1:0]      rs1_data;
  logic [core_pkg::xlen-1:0]      rs2_data;

  icache icache_i (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .hit      (hit),
    .inst     (inst),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack),
    .mem_line (mem_line),
    .flush    (redirect)
  );

  fetch_stage fetch_i (
    .clk         (clk),
    .rst         (rst),
    .hit         (hit),
    .inst        (inst),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc),
    .f_valid     (f_valid),
    .f_pc        (f_pc),
    .f_inst      (f_inst)
  );

  decode_stage decode_i (
    .clk            (clk),
    .rst            (rst),
    .f_valid        (f_valid),
    .f_pc           (f_pc),
    .f_inst         (f_inst),
    .hold           (hold),
    .redirect       (redirect),
    .stall          (stall),
    .rs1_idx        (rs1_idx),
    .rs2_idx        (rs2_idx),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .out_valid      (out_valid),
    .out_pc         (out_pc),
    .out_rd         (out_rd),
    .out_rs1_val    (out_rs1_val),
    .out_rs2_val    (out_rs2_val),
    .out_imm        (out_imm),
    .out_branch     (out_branch),
    .out_reg_write  (out_reg_write),
    .out_mem_read   (out_mem_read),
    .out_mem_to_reg (out_mem_to_reg),
    .out_mem_write  (out_mem_write),
    .out_alu_src    (out_alu_src),
    .out_alu_op     (out_alu_op)
  );

  register_file regfile_i (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wb_en),
    .wr_idx    (wb_idx),
    .wr_data   (wb_data),
    .rd_idx_1  (rs1_idx),
    .rd_idx_2  (rs2_idx),
    .rd_data_1 (rs1_data),
    .rd_data_2 (rs2_data)
  );

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             f_valid,
  input  wire  [core_pkg::xlen-1:0]       f_pc,
  input  wire  [core_pkg::xlen-1:0]       f_inst,
  input  wire                             hold,
  input  wire                             redirect,
  output logic                            stall,
  output logic [core_pkg::reg_idx_w-1:0]  rs1_idx,
  output logic [core_pkg::reg_idx_w-1:0]  rs2_idx,
  input  wire  [core_pkg::xlen-1:0]       rs1_data,
  input  wire  [core_pkg::xlen-1:0]       rs2_data,
  output logic                            out_valid,
  output logic [core_pkg::xlen-1:0]       out_pc,
  output logic [core_pkg::reg_idx_w-1:0]  out_rd,
  output logic [core_pkg::xlen-1:0]       out_rs1_val,
  output logic [core_pkg::xlen-1:0]       out_rs2_val,
  output logic [core_pkg::xlen-1:0]       out_imm,
  output logic                            out_branch,
  output logic                            out_reg_write,
  output logic                            out_mem_read,
  output logic                            out_mem_to_reg,
  output logic                            out_mem_write,
  output logic                            out_alu_src,
  output logic [1:0]                      out_alu_op
);

  core_pkg::inst_word_u       word;
  logic [core_pkg::xlen-1:0]  imm;
  logic [5:0]                 ctl;
  logic [1:0]                 alu_op;

  assign word    = f_inst;
  assign rs1_idx = word.r.rs1;
  assign rs2_idx = word.r.rs2;

  // Full register that execute refuses to take
  assign stall = out_valid && hold;

  // ctl = {branch, reg_write, mem_read, mem_to_reg, mem_write, alu_src}
  always_comb
  begin
    ctl    = '0;
    alu_op = core_pkg::alu_add;
    imm    = '0;
    case (word.r.opcode)
      core_pkg::op_r:
      begin
        ctl    = 6'b010000;
        alu_op = core_pkg::alu_func;
      end
      core_pkg::op_imm:
      begin
        ctl    = 6'b010001;
        alu_op = core_pkg::alu_func;
        imm    = {{20{word.i.imm12[11]}}, word.i.imm12};
      end
      core_pkg::op_load:
      begin
        ctl = 6'b011101;
        imm = {{20{word.i.imm12[11]}}, word.i.imm12};
      end
      core_pkg::op_store:
      begin
        // Store offset is split across funct7 and rd
        ctl = 6'b000011;
        imm = {{20{word.r.funct7[6]}}, word.r.funct7, word.r.rd};
      end
      core_pkg::op_branch:
      begin
        ctl    = 6'b100000;
        alu_op = core_pkg::alu_cmp;
        imm    = {{19{word.r.funct7[6]}}, word.r.funct7[6], word.r.rd[0],
                  word.r.funct7[5:0], word.r.rd[4:1], 1'b0};
      end
      default:
      begin
        ctl    = '0;
        alu_op = core_pkg::alu_add;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst || redirect)
    begin
      out_valid <= 1'b0;
    end
    else if (!stall)
    begin
      out_valid <= f_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      out_pc         <= f_pc;
      out_rd         <= word.r.rd;
      out_rs1_val    <= rs1_data;
      out_rs2_val    <= rs2_data;
      out_imm        <= imm;
      out_branch     <= ctl[5];
      out_reg_write  <= ctl[4];
      out_mem_read   <= ctl[3];
      out_mem_to_reg <= ctl[2];
      out_mem_write  <= ctl[1];
      out_alu_src    <= ctl[0];
      out_alu_op     <= alu_op;
    end
  end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        hit,
  input  wire  [core_pkg::xlen-1:0]  inst,
  input  wire                        stall,
  input  wire                        redirect,
  input  wire  [core_pkg::xlen-1:0]  redirect_pc,
  output logic [core_pkg::xlen-1:0]  pc,
  output logic                       f_valid,
  output logic [core_pkg::xlen-1:0]  f_pc,
  output logic [core_pkg::xlen-1:0]  f_inst
);

  logic advance;

  // Word accepted when the cache hits and decode can take the current one
  assign advance = hit && !stall && !redirect;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc      <= core_pkg::reset_pc;
      f_valid <= 1'b0;
    end
    else if (redirect)
    begin
      pc      <= redirect_pc;
      f_valid <= 1'b0;
    end
    else if (!stall)
    begin
      // On a miss decode still drains the register, so it goes empty
      f_valid <= hit;
      if (hit)
      begin
        pc <= pc + 32'd4;
      end
    end
  end

  // pc travels with its word for later stages
  always_ff @(posedge clk)
  begin
    if (advance)
    begin
      f_pc   <= pc;
      f_inst <= inst;
    end
  end

endmodule

`default_nettype wire

/* hw/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  [core_pkg::xlen-1:0]    pc,
  output logic                         hit,
  output logic [core_pkg::xlen-1:0]    inst,
  output logic                         mem_req,
  output logic [core_pkg::xlen-1:0]    mem_addr,
  input  wire                          mem_ack,
  input  wire  [core_pkg::line_w-1:0]  mem_line,
  input  wire                          flush
);

  logic                                valid_q [core_pkg::icache_lines];
  logic [core_pkg::icache_tag_w-1:0]   tag_q   [core_pkg::icache_lines];
  logic [core_pkg::line_w-1:0]         data_q  [core_pkg::icache_lines];

  logic [1:0]                          state_q;
  logic                                req_q;
  logic                                drop_q;
  logic [core_pkg::xlen-1:0]           addr_q;
  logic [core_pkg::line_w-1:0]         line_q;

  logic [core_pkg::icache_index_w-1:0] pc_index;
  logic [core_pkg::icache_tag_w-1:0]   pc_tag;
  logic [core_pkg::word_sel_w-1:0]     pc_word;
  logic [core_pkg::icache_index_w-1:0] fill_index;
  logic [core_pkg::icache_tag_w-1:0]   fill_tag;

  logic                                start_fill;
  logic                                take_line;
  logic                                write_line;

  // Address split into tag, index, word and byte
  assign pc_index   = pc[core_pkg::icache_offset_w +: core_pkg::icache_index_w];
  assign pc_tag     = pc[core_pkg::xlen-1 -: core_pkg::icache_tag_w];
  assign pc_word    = pc[2 +: core_pkg::word_sel_w];
  assign fill_index = addr_q[core_pkg::icache_offset_w +: core_pkg::icache_index_w];
  assign fill_tag   = addr_q[core_pkg::xlen-1 -: core_pkg::icache_tag_w];

  // Lookup straight from the tag and data flops
  assign hit  = valid_q[pc_index] && (tag_q[pc_index] == pc_tag);
  assign inst = data_q[pc_index][pc_word*core_pkg::xlen +: core_pkg::xlen];

  // No new request until memory has released ack
  assign start_fill = (state_q == core_pkg::refill_idle) && !hit && !flush && !mem_ack;
  assign take_line  = (state_q == core_pkg::refill_wait_ack) && mem_ack;
  // Line goes into the array once ack has dropped
  assign write_line = (state_q == core_pkg::refill_wait_release) && !mem_ack && !drop_q;

  assign mem_req  = req_q;
  assign mem_addr = addr_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= core_pkg::refill_idle;
      req_q   <= 1'b0;
      drop_q  <= 1'b0;
      for (int i = 0; i < core_pkg::icache_lines; i++)
      begin
        valid_q[i] <= 1'b0;
      end
    end
    else
    begin
      case (state_q)
        core_pkg::refill_idle:
        begin
          drop_q <= 1'b0;
          if (start_fill)
          begin
            req_q   <= 1'b1;
            state_q <= core_pkg::refill_wait_ack;
          end
        end
        core_pkg::refill_wait_ack:
        begin
          // Redirect makes this line unwanted but the handshake still runs
          if (flush)
          begin
            drop_q <= 1'b1;
          end
          if (take_line)
          begin
            req_q   <= 1'b0;
            state_q <= core_pkg::refill_wait_release;
          end
        end
        core_pkg::refill_wait_release:
        begin
          if (flush)
          begin
            drop_q <= 1'b1;
          end
          if (!mem_ack)
          begin
            state_q <= core_pkg::refill_idle;
          end
          if (write_line)
          begin
            valid_q[fill_index] <= 1'b1;
          end
        end
        default:
        begin
          state_q <= core_pkg::refill_idle;
          req_q   <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_fill)
    begin
      addr_q <= {pc[core_pkg::xlen-1:core_pkg::icache_offset_w],
                 {core_pkg::icache_offset_w{1'b0}}};
    end
    if (take_line)
    begin
      line_q <= mem_line;
    end
    if (write_line)
    begin
      tag_q[fill_index]  <= fill_tag;
      data_q[fill_index] <= line_q;
    end
  end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             wr_en,
  input  wire  [core_pkg::reg_idx_w-1:0]  wr_idx,
  input  wire  [core_pkg::xlen-1:0]       wr_data,
  input  wire  [core_pkg::reg_idx_w-1:0]  rd_idx_1,
  input  wire  [core_pkg::reg_idx_w-1:0]  rd_idx_2,
  output logic [core_pkg::xlen-1:0]       rd_data_1,
  output logic [core_pkg::xlen-1:0]       rd_data_2
);

  logic [core_pkg::xlen-1:0] regs_q [core_pkg::num_regs];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < core_pkg::num_regs; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    // Writes to x0 are dropped
    else if (wr_en && (wr_idx != '0))
    begin
      regs_q[wr_idx] <= wr_data;
    end
  end

  // Without a bypass a write shows up in the next cycle
  assign rd_data_1 = (rd_idx_1 == '0) ? '0 : regs_q[rd_idx_1];
  assign rd_data_2 = (rd_idx_2 == '0) ? '0 : regs_q[rd_idx_2];

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

  // Datapath and register file
  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;
  localparam int num_regs  = 32;

  // Instruction cache geometry
  localparam int line_w          = 128;
  localparam int words_per_line  = 4;
  localparam int word_sel_w      = 2;
  localparam int icache_lines    = 8;
  localparam int icache_index_w  = 3;
  localparam int icache_offset_w = 4;
  localparam int icache_tag_w    = 25;

  // First fetch address out of reset
  localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

  // Major opcodes
  localparam logic [6:0] op_r      = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  // ALU operation classes handed to execute
  localparam logic [1:0] alu_add  = 2'b00;
  localparam logic [1:0] alu_sub  = 2'b01;
  localparam logic [1:0] alu_func = 2'b10;
  localparam logic [1:0] alu_cmp  = 2'b11;

  // Refill FSM states of the instruction cache
  localparam logic [1:0] refill_idle         = 2'b00;
  localparam logic [1:0] refill_wait_ack     = 2'b01;
  localparam logic [1:0] refill_wait_release = 2'b10;

  // Same 32-bit word seen as R type or I type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } inst_word_u;

endpackage

`default_nettype wire
